//--- compile.f
+incdir+source
source/rsp_order_pkg.sv
source/rsp_msg_pkg.sv
source/rsp_order_if.sv
source/slot_ram.sv
source/req_tagger.sv
source/read_rob.sv
source/write_heap.sv
source/rsp_assemble.sv
source/rsp_order_shim.sv
tb/fiu_model.sv
tb/rsp_order_tb.sv

//--- tb/rsp_order_tb.sv
// Testbench for the response ordering shim
// Runs random reads and writes against a shuffling fabric model, then holds
// responses back to fill the reorder buffer up to almost-full.
// Assertions compare every response with queues of expected values
`timescale 1ns/100ps

`include "rsp_order_consts.svh"

module rsp_order_tb;

    localparam int N_RD     = 48;
    localparam int N_WR     = 48;
    localparam int N_REQ    = N_RD + N_WR + `RSP_ORDER_ENTRIES;
    localparam int TIMEOUT  = N_REQ * 40 + 200;
    localparam int AF_LEVEL = `RSP_ORDER_ENTRIES - `RSP_ORDER_AF_RESERVE;

    logic                    clk;
    logic                    reset;
    logic                    rd_req_valid, wr_req_valid, rd_almost_full, wr_almost_full;
    rsp_order_pkg::t_mdata   rd_req_mdata, wr_req_mdata, rd_rsp_mdata, wr_rsp_mdata;
    logic                    fabric_rd_almost_full, fabric_wr_almost_full;
    logic                    fabric_rd_req_valid, fabric_wr_req_valid;
    logic                    fabric_rd_rsp_valid, fabric_wr_rsp_valid;
    rsp_order_pkg::t_req_idx fabric_rd_req_tag, fabric_wr_req_tag;
    rsp_order_pkg::t_req_idx fabric_rd_rsp_tag, fabric_wr_rsp_tag;
    rsp_order_pkg::t_line    fabric_rd_rsp_data, rd_rsp_data;
    logic                    rd_rsp_valid, wr_rsp_valid;
    logic                    hold_rsp;
    logic [31:0]             rnd;
    int                      cycles = 0;
    int                      errors = 0;
    int                      tag_errors;

    // ==============================
    // Expected values
    // ==============================

    rsp_order_pkg::t_mdata rd_mdata_q [$];
    rsp_order_pkg::t_line  rd_line_q [$];
    rsp_order_pkg::t_mdata wr_pend_q [$];
    rsp_order_pkg::t_mdata wr_by_tag [`RSP_ORDER_ENTRIES];
    logic                  rd_exp_avail, wr_exp_v1, wr_exp_v2, req_seen;
    rsp_order_pkg::t_mdata rd_exp_mdata, wr_exp_m1, wr_exp_m2;
    rsp_order_pkg::t_line  rd_exp_line;
    logic [31:0]           rd_issue;
    int                    rd_outstanding, wr_outstanding;

    rsp_order_shim rsp_order_shim_inst (.*);

    fiu_model fiu_model_inst (
        .clk, .reset, .rnd,
        .hold         (hold_rsp),
        .rd_req_valid (fabric_rd_req_valid),
        .rd_req_tag   (fabric_rd_req_tag),
        .wr_req_valid (fabric_wr_req_valid),
        .wr_req_tag   (fabric_wr_req_tag),
        .rd_rsp_valid (fabric_rd_rsp_valid),
        .rd_rsp_tag   (fabric_rd_rsp_tag),
        .rd_rsp_data  (fabric_rd_rsp_data),
        .wr_rsp_valid (fabric_wr_rsp_valid),
        .wr_rsp_tag   (fabric_wr_rsp_tag),
        .tag_errors   (tag_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reads return in issue order, so the queue head is always the next one.
    // A write's metadata is looked up by the tag the fabric saw it with
    always @(posedge clk)
    begin
        if (reset)
        begin
            rnd            <= 32'h7fe2_830d;
            rd_outstanding <= 0;
            wr_outstanding <= 0;
            req_seen       <= 1'b0;
            rd_exp_avail   <= 1'b0;
            wr_exp_v1      <= 1'b0;
            wr_exp_v2      <= 1'b0;
            rd_issue       = '0;
        end
        else
        begin
            rnd <= xorshift(rnd);
            if (rd_rsp_valid && rd_mdata_q.size() > 0)
            begin
                void'(rd_mdata_q.pop_front());
                void'(rd_line_q.pop_front());
            end
            if (rd_req_valid)
            begin
                rd_mdata_q.push_back(rd_req_mdata);
                rd_line_q.push_back({~rd_issue, rd_issue});
                rd_issue = rd_issue + 1;
            end
            rd_exp_avail <= rd_mdata_q.size() > 0;
            if (rd_mdata_q.size() > 0)
            begin
                rd_exp_mdata <= rd_mdata_q[0];
                rd_exp_line  <= rd_line_q[0];
            end
            // Write results trail their fabric response by two stages
            if (fabric_wr_rsp_valid)
                wr_exp_m1 <= wr_by_tag[fabric_wr_rsp_tag];
            wr_exp_v1 <= fabric_wr_rsp_valid;
            wr_exp_v2 <= wr_exp_v1;
            wr_exp_m2 <= wr_exp_m1;
            if (fabric_wr_req_valid && wr_pend_q.size() > 0)
                wr_by_tag[fabric_wr_req_tag] = wr_pend_q.pop_front();
            if (wr_req_valid)
                wr_pend_q.push_back(wr_req_mdata);
            rd_outstanding <= rd_outstanding + int'(rd_req_valid) - int'(rd_rsp_valid);
            wr_outstanding <= wr_outstanding + int'(wr_req_valid) - int'(wr_rsp_valid);
            req_seen       <= req_seen || rd_req_valid || wr_req_valid;
        end
    end

    // ==============================
    // Checks
    // ==============================

    assert property (@(posedge clk) disable iff (reset) !req_seen |->
        !(rd_rsp_valid || wr_rsp_valid || fabric_rd_req_valid || fabric_wr_req_valid))
    else
    begin
        errors++;
        $display("A valid output rose at %0t before any request was driven", $time);
    end

    assert property (@(posedge clk) disable iff (reset) !req_seen |->
        rd_almost_full == fabric_rd_almost_full && wr_almost_full == fabric_wr_almost_full)
    else
    begin
        errors++;
        $display("** Error at %0t: rd_almost_full/wr_almost_full are %b/%b, expected %b/%b",
                 $time, $sampled(rd_almost_full), $sampled(wr_almost_full),
                 $sampled(fabric_rd_almost_full), $sampled(fabric_wr_almost_full));
    end

    // The fabric level always passes straight through
    assert property (@(posedge clk) disable iff (reset)
        (!fabric_rd_almost_full || rd_almost_full) && (!fabric_wr_almost_full || wr_almost_full))
    else
    begin
        errors++;
        $display("Almost-full stayed low at %0t while the fabric's was high", $time);
    end

    assert property (@(posedge clk) disable iff (reset) rd_rsp_valid |-> rd_exp_avail)
    else
    begin
        errors++;
        $display("Read response at %0t with no read outstanding", $time);
    end

    assert property (@(posedge clk) disable iff (reset) rd_rsp_valid |-> rd_rsp_mdata == rd_exp_mdata)
    else
    begin
        errors++;
        $display("** Error at %0t: rd_rsp_mdata is %h, expected %h",
                 $time, $sampled(rd_rsp_mdata), $sampled(rd_exp_mdata));
    end

    assert property (@(posedge clk) disable iff (reset) rd_rsp_valid |-> rd_rsp_data == rd_exp_line)
    else
    begin
        errors++;
        $display("** Error at %0t: rd_rsp_data is %h, expected %h",
                 $time, $sampled(rd_rsp_data), $sampled(rd_exp_line));
    end

    assert property (@(posedge clk) disable iff (reset) wr_rsp_valid == wr_exp_v2)
    else
    begin
        errors++;
        $display("** Error at %0t: wr_rsp_valid is %b, expected %b",
                 $time, $sampled(wr_rsp_valid), $sampled(wr_exp_v2));
    end

    assert property (@(posedge clk) disable iff (reset) wr_exp_v2 |-> wr_rsp_mdata == wr_exp_m2)
    else
    begin
        errors++;
        $display("** Error at %0t: wr_rsp_mdata is %h, expected %h",
                 $time, $sampled(wr_rsp_mdata), $sampled(wr_exp_m2));
    end

    // With nothing draining, the reserve must be announced in time
    assert property (@(posedge clk) disable iff (reset)
        hold_rsp && rd_outstanding >= AF_LEVEL |-> rd_almost_full)
    else
    begin
        errors++;
        $display("rd_almost_full still low at %0t with %0d reads outstanding",
                 $time, $sampled(rd_outstanding));
    end

    assert property (@(posedge clk) disable iff (reset)
        (rd_outstanding == 0 && !fabric_rd_almost_full |-> !rd_almost_full) and
        (wr_outstanding == 0 && !fabric_wr_almost_full |-> !wr_almost_full))
    else
    begin
        errors++;
        $display("Almost-full still high at %0t with the shim empty", $time);
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("Timeout after %0d cycles with %0d reads and %0d writes outstanding",
                     cycles, rd_outstanding, wr_outstanding);
            $display("Testbench failed");
            $finish;
        end
    end

    // Counters lag a request by one cycle, so look only after that
    task automatic wait_drained();
        repeat (2) @(posedge clk);
        while (rd_outstanding != 0 || wr_outstanding != 0)
            @(posedge clk);
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin : stimulus
        int   rd_sent;
        int   wr_sent;
        int   held;
        logic go_rd;
        logic go_wr;
        reset                 = 1'b1;
        rd_req_valid          = 1'b0;
        rd_req_mdata          = '0;
        wr_req_valid          = 1'b0;
        wr_req_mdata          = '0;
        fabric_rd_almost_full = 1'b0;
        fabric_wr_almost_full = 1'b0;
        hold_rsp              = 1'b0;
        rd_sent               = 0;
        wr_sent               = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // Idle with a moving fabric level and no requests
        repeat (10)
        begin
            @(posedge clk);
            fabric_rd_almost_full <= rnd[27];
            fabric_wr_almost_full <= rnd[28];
        end
        // Random traffic that stops issuing while almost-full is high
        while (rd_sent < N_RD || wr_sent < N_WR)
        begin
            @(posedge clk);
            go_rd = rnd[24] && !rd_almost_full && rd_sent < N_RD;
            go_wr = rnd[25] && !wr_almost_full && wr_sent < N_WR;
            rd_req_valid          <= go_rd;
            wr_req_valid          <= go_wr;
            rd_req_mdata          <= rnd[31:16];
            wr_req_mdata          <= rnd[15:0];
            fabric_rd_almost_full <= rnd[22:20] == 3'd0;
            fabric_wr_almost_full <= rnd[30:28] == 3'd0;
            rd_sent += int'(go_rd);
            wr_sent += int'(go_wr);
        end
        @(posedge clk);
        rd_req_valid          <= 1'b0;
        wr_req_valid          <= 1'b0;
        fabric_rd_almost_full <= 1'b0;
        fabric_wr_almost_full <= 1'b0;
        wait_drained();
        // Hold every response and issue reads until almost-full rises
        hold_rsp <= 1'b1;
        held = 0;
        @(posedge clk);
        while (!rd_almost_full && held < `RSP_ORDER_ENTRIES)
        begin
            rd_req_valid <= 1'b1;
            rd_req_mdata <= rnd[31:16];
            held++;
            @(posedge clk);
        end
        rd_req_valid <= 1'b0;
        repeat (20) @(posedge clk);
        hold_rsp <= 1'b0;
        wait_drained();
        repeat (4) @(posedge clk);
        $display("Checks done with %0d response errors and %0d tag errors", errors, tag_errors);
        if (errors == 0 && tag_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb/fiu_model.sv
// Fabric model for the response ordering shim testbench
// Collects tagged read and write requests and answers at most one per
// channel per cycle, picking a random outstanding request each time.
// Read data is built from the request's issue number. hold stops all answers
`timescale 1ns/100ps

`include "rsp_order_consts.svh"

module fiu_model (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hold,
    input  logic [31:0]             rnd,
    input  logic                    rd_req_valid,
    input  rsp_order_pkg::t_req_idx rd_req_tag,
    input  logic                    wr_req_valid,
    input  rsp_order_pkg::t_req_idx wr_req_tag,
    output logic                    rd_rsp_valid,
    output rsp_order_pkg::t_req_idx rd_rsp_tag,
    output rsp_order_pkg::t_line    rd_rsp_data,
    output logic                    wr_rsp_valid,
    output rsp_order_pkg::t_req_idx wr_rsp_tag,
    output int                      tag_errors
);

    // Outstanding requests in arrival order, reads with their issue number
    rsp_order_pkg::t_req_idx       rd_tags [$];
    logic [31:0]                   rd_issue [$];
    rsp_order_pkg::t_req_idx       wr_tags [$];
    logic [`RSP_ORDER_ENTRIES-1:0] rd_busy;
    logic [`RSP_ORDER_ENTRIES-1:0] wr_busy;
    int                            rd_count;

    initial
    begin
        tag_errors   = 0;
        rd_rsp_valid = 1'b0;
        rd_rsp_tag   = '0;
        rd_rsp_data  = '0;
        wr_rsp_valid = 1'b0;
        wr_rsp_tag   = '0;
    end

    always @(posedge clk)
    begin : respond
        int pick;
        rd_rsp_valid <= 1'b0;
        wr_rsp_valid <= 1'b0;
        if (reset)
        begin
            rd_tags.delete();
            rd_issue.delete();
            wr_tags.delete();
            rd_busy  <= '0;
            wr_busy  <= '0;
            rd_count = 0;
        end
        else
        begin
            // Answer a random outstanding read about every other cycle
            if (!hold && rnd[0] && rd_tags.size() > 0)
            begin
                pick = int'(rnd[11:4]) % rd_tags.size();
                rd_rsp_valid           <= 1'b1;
                rd_rsp_tag             <= rd_tags[pick];
                rd_rsp_data            <= {~rd_issue[pick], rd_issue[pick]};
                rd_busy[rd_tags[pick]] <= 1'b0;
                rd_tags.delete(pick);
                rd_issue.delete(pick);
            end
            // Writes are shuffled the same way from other random bits
            if (!hold && rnd[1] && wr_tags.size() > 0)
            begin
                pick = int'(rnd[19:12]) % wr_tags.size();
                wr_rsp_valid           <= 1'b1;
                wr_rsp_tag             <= wr_tags[pick];
                wr_busy[wr_tags[pick]] <= 1'b0;
                wr_tags.delete(pick);
            end
            // New requests wait at least one cycle before they can be answered
            if (rd_req_valid)
            begin
                rd_tags.push_back(rd_req_tag);
                rd_issue.push_back(rd_count);
                rd_busy[rd_req_tag] <= 1'b1;
                rd_count = rd_count + 1;
            end
            if (wr_req_valid)
            begin
                wr_tags.push_back(wr_req_tag);
                wr_busy[wr_req_tag] <= 1'b1;
            end
        end
    end

    // A tag must not come back to the fabric until its response has gone out
    assert property (@(posedge clk) disable iff (reset) rd_req_valid |-> !rd_busy[rd_req_tag])
    else
    begin
        tag_errors++;
        $display("Read tag %0d reused at %0t while still outstanding", $sampled(rd_req_tag), $time);
    end

    assert property (@(posedge clk) disable iff (reset) wr_req_valid |-> !wr_busy[wr_req_tag])
    else
    begin
        tag_errors++;
        $display("Write tag %0d reused at %0t while still outstanding", $sampled(wr_req_tag), $time);
    end

endmodule

//--- source/rsp_order_shim.sv
// Top level of the response ordering shim between accelerator and fabric
// Reads come back in request order and writes keep their metadata.
// Requests reach the fabric one cycle after issue, write responses
// return two cycles after the fabric answers
`timescale 1ns/100ps

module rsp_order_shim (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_req_valid,
    input  rsp_order_pkg::t_mdata   rd_req_mdata,
    output logic                    rd_almost_full,
    input  logic                    wr_req_valid,
    input  rsp_order_pkg::t_mdata   wr_req_mdata,
    output logic                    wr_almost_full,
    input  logic                    fabric_rd_almost_full,
    input  logic                    fabric_wr_almost_full,
    output logic                    fabric_rd_req_valid,
    output rsp_order_pkg::t_req_idx fabric_rd_req_tag,
    output logic                    fabric_wr_req_valid,
    output rsp_order_pkg::t_req_idx fabric_wr_req_tag,
    input  logic                    fabric_rd_rsp_valid,
    input  rsp_order_pkg::t_req_idx fabric_rd_rsp_tag,
    input  rsp_order_pkg::t_line    fabric_rd_rsp_data,
    input  logic                    fabric_wr_rsp_valid,
    input  rsp_order_pkg::t_req_idx fabric_wr_rsp_tag,
    output logic                    rd_rsp_valid,
    output rsp_order_pkg::t_mdata   rd_rsp_mdata,
    output rsp_order_pkg::t_line    rd_rsp_data,
    output logic                    wr_rsp_valid,
    output rsp_order_pkg::t_mdata   wr_rsp_mdata
);

    req_tag_if    rd_tag_if ();
    req_tag_if    wr_tag_if ();
    rsp_result_if result_if ();

    // ==============================
    // Decode, execute and result
    // ==============================

    req_tagger req_tagger_inst (
        .clk, .reset,
        .rd_req_valid, .rd_req_mdata, .wr_req_valid, .wr_req_mdata,
        .fabric_rd_almost_full, .fabric_wr_almost_full,
        .rd_almost_full, .wr_almost_full,
        .fabric_rd_req_valid, .fabric_rd_req_tag,
        .fabric_wr_req_valid, .fabric_wr_req_tag,
        .rd_tag (rd_tag_if.tagger),
        .wr_tag (wr_tag_if.tagger)
    );

    // Read responses fill the reorder buffer at their tag
    read_rob read_rob_inst (
        .clk, .reset,
        .alloc      (rd_tag_if.store),
        .fill_valid (fabric_rd_rsp_valid),
        .fill_tag   (fabric_rd_rsp_tag),
        .fill_data  (fabric_rd_rsp_data),
        .result     (result_if.rob)
    );

    // Write responses free their heap slot
    write_heap write_heap_inst (
        .clk, .reset,
        .alloc      (wr_tag_if.store),
        .free_valid (fabric_wr_rsp_valid),
        .free_tag   (fabric_wr_rsp_tag),
        .result     (result_if.heap)
    );

    rsp_assemble rsp_assemble_inst (
        .clk, .reset,
        .result (result_if.assemble),
        .rd_rsp_valid, .rd_rsp_mdata, .rd_rsp_data,
        .wr_rsp_valid, .wr_rsp_mdata
    );

endmodule

//--- source/rsp_assemble.sv
// Result stage of the response ordering shim
// Registers the restored read and write records onto the accelerator's
// response ports. Adds one cycle to both channels
`timescale 1ns/100ps

module rsp_assemble (
    input  logic                  clk,
    input  logic                  reset,
    rsp_result_if.assemble        result,
    output logic                  rd_rsp_valid,
    output rsp_order_pkg::t_mdata rd_rsp_mdata,
    output rsp_order_pkg::t_line  rd_rsp_data,
    output logic                  wr_rsp_valid,
    output rsp_order_pkg::t_mdata wr_rsp_mdata
);

    // Response strobes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_rsp_valid <= 1'b0;
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= result.rd.valid;
            wr_rsp_valid <= result.wr.valid;
        end
    end

    // Payload follows its strobe and is only meaningful with it
    always_ff @(posedge clk)
    begin
        rd_rsp_mdata <= result.rd.mdata;
        rd_rsp_data  <= result.rd.data;
        wr_rsp_mdata <= result.wr.mdata;
    end

endmodule

//--- source/write_heap.sv
// Write metadata heap
// A free-index bitmap offers the lowest free slot to each write request.
// The metadata waits in the slot until the fabric returns that tag, then
// it is read back and the slot goes back on the free list
`timescale 1ns/100ps

`include "rsp_order_consts.svh"

module write_heap (
    input  logic                    clk,
    input  logic                    reset,
    req_tag_if.store                alloc,
    input  logic                    free_valid,
    input  rsp_order_pkg::t_req_idx free_tag,
    rsp_result_if.heap              result
);

    localparam int CNT_W = $clog2(`RSP_ORDER_ENTRIES) + 1;

    logic [`RSP_ORDER_ENTRIES-1:0] free_map;
    logic [CNT_W-1:0]              free_cnt;
    rsp_order_pkg::t_req_idx       low_idx;
    rsp_order_pkg::t_mdata         rsp_mdata;
    logic                          wr_valid_q;

    // Lowest set bit of the free map. Scanning down leaves the lowest
    always_comb
    begin
        low_idx = '0;
        for (int i = `RSP_ORDER_ENTRIES - 1; i >= 0; i--)
        begin
            if (free_map[i])
            begin
                low_idx = rsp_order_pkg::t_req_idx'(i);
            end
        end
    end

    assign alloc.alloc_idx = low_idx;
    assign alloc.not_full  = free_cnt > CNT_W'(`RSP_ORDER_AF_RESERVE);

    // Metadata goes in at allocation and is looked up by the returned tag
    slot_ram #(.t_entry(rsp_order_pkg::t_mdata)) mdata_ram (
        .clk     (clk),
        .wr_en   (alloc.alloc),
        .wr_idx  (low_idx),
        .wr_data (alloc.alloc_mdata),
        .rd_idx  (free_tag),
        .rd_data (rsp_mdata)
    );

    // The slot read is registered, so freeing it in the same cycle is safe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_map   <= '1;
            free_cnt   <= CNT_W'(`RSP_ORDER_ENTRIES);
            wr_valid_q <= 1'b0;
        end
        else
        begin
            if (alloc.alloc)
            begin
                free_map[low_idx] <= 1'b0;
            end
            if (free_valid)
            begin
                free_map[free_tag] <= 1'b1;
            end
            free_cnt   <= free_cnt - CNT_W'(alloc.alloc) + CNT_W'(free_valid);
            wr_valid_q <= free_valid;
        end
    end

    assign result.wr = '{valid: wr_valid_q, mdata: rsp_mdata};

endmodule

//--- source/read_rob.sv
// Read reorder buffer
// Indices are handed out in order from a tail pointer. Fabric data fills
// entries in any order, and the head entry drains as soon as it is filled,
// so read results leave in request order with the original metadata
`timescale 1ns/100ps

`include "rsp_order_consts.svh"

module read_rob (
    input  logic                    clk,
    input  logic                    reset,
    req_tag_if.store                alloc,
    input  logic                    fill_valid,
    input  rsp_order_pkg::t_req_idx fill_tag,
    input  rsp_order_pkg::t_line    fill_data,
    rsp_result_if.rob               result
);

    // Wide enough to count a completely full buffer
    localparam int CNT_W = $clog2(`RSP_ORDER_ENTRIES) + 1;

    rsp_order_pkg::t_req_idx       head;
    rsp_order_pkg::t_req_idx       tail;
    logic [`RSP_ORDER_ENTRIES-1:0] filled;
    logic [CNT_W-1:0]              used_cnt;
    logic                          deq;
    logic                          rd_valid_q;
    rsp_order_pkg::t_mdata         head_mdata;
    rsp_order_pkg::t_line          head_line;

    // ==============================
    // Allocation
    // ==============================

    assign alloc.alloc_idx = tail;

    // Keep the reserve free so late requests still find room
    assign alloc.not_full = (CNT_W'(`RSP_ORDER_ENTRIES) - used_cnt) >
                            CNT_W'(`RSP_ORDER_AF_RESERVE);

    // Metadata is written at allocation, data when the fabric returns it
    slot_ram #(.t_entry(rsp_order_pkg::t_mdata)) mdata_ram (
        .clk     (clk),
        .wr_en   (alloc.alloc),
        .wr_idx  (tail),
        .wr_data (alloc.alloc_mdata),
        .rd_idx  (head),
        .rd_data (head_mdata)
    );

    slot_ram #(.t_entry(rsp_order_pkg::t_line)) line_ram (
        .clk     (clk),
        .wr_en   (fill_valid),
        .wr_idx  (fill_tag),
        .wr_data (fill_data),
        .rd_idx  (head),
        .rd_data (head_line)
    );

    // ==============================
    // Fill and drain
    // ==============================

    // Both memories are already reading the head, so the entry is
    // available one cycle after its filled bit is seen
    assign deq = filled[head];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head       <= '0;
            tail       <= '0;
            filled     <= '0;
            used_cnt   <= '0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            // Tags are unique, so a fill never hits the entry being drained
            if (deq)
            begin
                filled[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            if (fill_valid)
            begin
                filled[fill_tag] <= 1'b1;
            end
            if (alloc.alloc)
            begin
                tail <= tail + 1'b1;
            end
            used_cnt   <= used_cnt + CNT_W'(alloc.alloc) - CNT_W'(deq);
            rd_valid_q <= deq;
        end
    end

    assign result.rd = '{valid: rd_valid_q, mdata: head_mdata, data: head_line};

endmodule

//--- source/req_tagger.sv
// Request tagging stage of the response ordering shim
// Each accelerator request takes an index from its channel's store, which
// keeps the metadata. The request goes to the fabric one cycle later with
// that index as its tag. Almost-full merges fabric level and store space
`timescale 1ns/100ps

module req_tagger (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_req_valid,
    input  rsp_order_pkg::t_mdata   rd_req_mdata,
    input  logic                    wr_req_valid,
    input  rsp_order_pkg::t_mdata   wr_req_mdata,
    input  logic                    fabric_rd_almost_full,
    input  logic                    fabric_wr_almost_full,
    output logic                    rd_almost_full,
    output logic                    wr_almost_full,
    output logic                    fabric_rd_req_valid,
    output rsp_order_pkg::t_req_idx fabric_rd_req_tag,
    output logic                    fabric_wr_req_valid,
    output rsp_order_pkg::t_req_idx fabric_wr_req_tag,
    req_tag_if.tagger               rd_tag,
    req_tag_if.tagger               wr_tag
);

    // Every request allocates. The store keeps the original metadata
    assign rd_tag.alloc       = rd_req_valid;
    assign rd_tag.alloc_mdata = rd_req_mdata;
    assign wr_tag.alloc       = wr_req_valid;
    assign wr_tag.alloc_mdata = wr_req_mdata;

    // The store's reserve covers requests that arrive after this rises
    assign rd_almost_full = fabric_rd_almost_full || !rd_tag.not_full;
    assign wr_almost_full = fabric_wr_almost_full || !wr_tag.not_full;

    // Request strobes toward the fabric
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fabric_rd_req_valid <= 1'b0;
            fabric_wr_req_valid <= 1'b0;
        end
        else
        begin
            fabric_rd_req_valid <= rd_req_valid;
            fabric_wr_req_valid <= wr_req_valid;
        end
    end

    // The tag replaces the metadata on the way out
    always_ff @(posedge clk)
    begin
        fabric_rd_req_tag <= rd_tag.alloc_idx;
        fabric_wr_req_tag <= wr_tag.alloc_idx;
    end

endmodule

//--- source/slot_ram.sv
// Small indexed memory with one write port and a registered read port
// The entry type is a parameter so one module serves metadata and lines
// Read data for rd_idx appears on the cycle after the index is presented
`timescale 1ns/100ps

`include "rsp_order_consts.svh"

module slot_ram #(
    parameter type t_entry = logic
) (
    input  logic                    clk,
    input  logic                    wr_en,
    input  rsp_order_pkg::t_req_idx wr_idx,
    input  t_entry                  wr_data,
    input  rsp_order_pkg::t_req_idx rd_idx,
    output t_entry                  rd_data
);

    // One entry per buffer slot
    t_entry mem [`RSP_ORDER_ENTRIES];

    // Write and read share the clock. A read of the slot being written
    // returns the old contents
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx];
    end

endmodule

//--- source/rsp_order_if.sv
// Interfaces between the shim stages
// req_tag_if hands a buffer index to the tagger and takes the metadata to keep
// rsp_result_if carries the restored responses to the assembler
`timescale 1ns/100ps

// One instance per channel. A cycle with alloc high consumes alloc_idx
// and stores alloc_mdata in that entry
interface req_tag_if;
    logic                    alloc;
    rsp_order_pkg::t_mdata   alloc_mdata;
    rsp_order_pkg::t_req_idx alloc_idx;
    logic                    not_full;

    // The tagger requests, the storage module offers an index and space
    modport tagger (output alloc, output alloc_mdata, input alloc_idx, input not_full);
    modport store (input alloc, input alloc_mdata, output alloc_idx, output not_full);
endinterface

// Restored responses from both storage modules
interface rsp_result_if;
    rsp_msg_pkg::t_rd_rsp rd;
    rsp_msg_pkg::t_wr_rsp wr;

    // Each storage module drives only its own record
    modport rob (output rd);
    modport heap (output wr);
    modport assemble (input rd, input wr);
endinterface

//--- source/rsp_msg_pkg.sv
// Response record types for the result stage of the shim
// The reorder buffer and heap drive these records and the assembler
// registers them toward the accelerator

package rsp_msg_pkg;

    // ==============================
    // Restored responses
    // ==============================

    // Read response with its original metadata, returned in request order
    typedef struct packed {
        logic                  valid;
        rsp_order_pkg::t_mdata mdata;
        rsp_order_pkg::t_line  data;
    } t_rd_rsp;

    // Write response with its original metadata
    typedef struct packed {
        logic                  valid;
        rsp_order_pkg::t_mdata mdata;
    } t_wr_rsp;

endpackage

//--- source/rsp_order_pkg.sv
// Storage-side types for the response ordering shim
// Used by the tagger, the reorder buffer, the heap and the slot memories
// Refer to the types with package-scoped names

`include "rsp_order_consts.svh"

package rsp_order_pkg;

    // ==============================
    // Index and payload types
    // ==============================

    // Buffer index, which is also the tag sent to the fabric
    typedef logic [$clog2(`RSP_ORDER_ENTRIES)-1:0] t_req_idx;

    // Accelerator metadata that must come back on the response
    typedef logic [`RSP_ORDER_MDATA_W-1:0] t_mdata;

    // One read data line
    typedef logic [`RSP_ORDER_LINE_W-1:0] t_line;

endpackage

//--- source/rsp_order_consts.svh
// Sizing constants for the response ordering shim
// Include this wherever buffer depth, field widths or the almost-full
// reserve are needed. The packages build their types from these values

`ifndef RSP_ORDER_CONSTS_SVH
`define RSP_ORDER_CONSTS_SVH

// Entries in the read reorder buffer and in the write heap
// Must be a power of two so that tag arithmetic wraps naturally
`define RSP_ORDER_ENTRIES 16

// Accelerator metadata carried with every request
`define RSP_ORDER_MDATA_W 16

// Read data line returned by the fabric
`define RSP_ORDER_LINE_W 64

// Requests the accelerator may still issue after almost-full rises
`define RSP_ORDER_AF_RESERVE 2

`endif
